//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       = tb_hub75_top
FLIST     = flist.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

# build and run, a $$fatal in the run gives a failing exit status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- brightness_timeout.sv
/* output-enable window for the plane latched with the row
   window = base timeout times the one-hot mask, a zero mask gives none */
`timescale 1ns/1ps
`include "matrix_consts.svh"

module brightness_timeout (
    input  logic                          clk_in,
    input  logic                          reset,
    input  logic                          row_latch,
    input  logic [`BRIGHTNESS_LEVELS-1:0] brightness_mask_active,
    output logic                          output_enable,
    output logic                          exceeded_overlap_time
);

    // longest window belongs to the MSB plane
    localparam int MAX_WINDOW = `BRIGHTNESS_BASE_TIMEOUT << (`BRIGHTNESS_LEVELS - 1);
    localparam int WINDOW_BITS = $clog2(MAX_WINDOW + 1);

    logic [WINDOW_BITS-1:0] window_length;
    logic [WINDOW_BITS-1:0] window_count;

    // mask is one-hot, so this is base shifted by the plane index
    assign window_length = WINDOW_BITS'(`BRIGHTNESS_BASE_TIMEOUT * brightness_mask_active);

    // row_latch seen here on the posedge inside its high phase
    // active mask still holds the previous plane at that point
    always_ff @(posedge clk_in) begin
        if (reset) begin
            window_count <= '0;
        end else if (row_latch) begin
            window_count <= window_length;
        end else if (window_count != '0) begin
            window_count <= window_count - 1'b1;
        end
    end

    assign output_enable = (window_count != '0);

    // remaining count small enough to start shifting the next line
    assign exceeded_overlap_time = output_enable
        && (window_count <= WINDOW_BITS'(`BRIGHTNESS_STATE_TIMEOUT_OVERLAP));

    // mask comes from the negedge scan logic, check it stays a plane select
    a_mask_onehot0: assert property (
        @(posedge clk_in) disable iff (reset)
        $onehot0(brightness_mask_active)
    ) else $error("active brightness mask not one-hot");

    // previous window has to be dark by the time the next row is latched
    a_dark_at_latch: assert property (
        @(posedge clk_in) disable iff (reset)
        !(output_enable && row_latch)
    ) else $error("output_enable high during row_latch");

endmodule

//--- flist.f
+incdir+.
matrix_pkg.sv
timeout.sv
brightness_timeout.sv
matrix_scan.sv
test_pattern.sv
hub75_top.sv
tb_hub75_top.sv

//--- hub75_top.sv
/* HUB75 panel driver with a built-in test pattern
   output_enable is active high, any pin inversion is on the board */
`timescale 1ns/1ps

module hub75_top (
    input  logic                   clk_in,
    input  logic                   reset,
    output matrix_pkg::scan_ctrl_t ctrl,
    output matrix_pkg::scan_pos_t  pos,
    output matrix_pkg::rgb_pair_t  rgb
);

    // scan timing, gated clocks and addresses
    matrix_scan i_matrix_scan (
        .reset (reset),
        .clk_in(clk_in),
        .ctrl  (ctrl),
        .pos   (pos)
    );

    // colour bits follow the scan position with no delay
    // panel samples them on the clk_pixel rising edge
    test_pattern i_test_pattern (
        .pos(pos),
        .rgb(rgb)
    );

endmodule

//--- matrix_consts.svh
/* panel geometry and BCM timing for the 64x32 HUB75 driver
   the overlap budget must stay below the 64-cycle load burst */
`ifndef MATRIX_CONSTS_SVH
`define MATRIX_CONSTS_SVH

// columns shifted out per line
`define PIXEL_WIDTH 64

// rows per half, upper and lower halves scan together
`define PIXEL_HALFHEIGHT 16

// bit planes of binary-coded modulation
`define BRIGHTNESS_LEVELS 4

// clk_in cycles of output enable for the LSB plane
`define BRIGHTNESS_BASE_TIMEOUT 20

// next line may start once this little of the window is left
`define BRIGHTNESS_STATE_TIMEOUT_OVERLAP 40

// derived address widths
`define COLUMN_BITS ($clog2(`PIXEL_WIDTH))
`define ROW_BITS ($clog2(`PIXEL_HALFHEIGHT))

`endif

//--- matrix_pkg.sv
/* bundles passed between scan controller, pattern source and panel pins
   field order fixes the packed bit layout, first field is the MSB */
`include "matrix_consts.svh"

package matrix_pkg;

    // panel control strobes and clocks
    typedef struct packed {
        // gated clk_in, one pulse per column
        logic clk_pixel_load;
        // same burst, half a cycle later
        logic clk_pixel;
        // one cycle, after the last column
        logic row_latch;
        // active high, board inverts if needed
        logic output_enable;
    } scan_ctrl_t;

    // where the scan is right now
    typedef struct packed {
        // counts 63 down to 0 during a line
        logic [`COLUMN_BITS-1:0] column_address;
        // row being shifted in
        logic [`ROW_BITS-1:0] row_address;
        // row currently lit
        logic [`ROW_BITS-1:0] row_address_active;
        // one-hot plane select for the line being shifted
        logic [`BRIGHTNESS_LEVELS-1:0] brightness_mask;
    } scan_pos_t;

    // colour bits, 0 = upper half, 1 = lower half
    typedef struct packed {
        logic r0;
        logic g0;
        logic b0;
        logic r1;
        logic g1;
        logic b1;
    } rgb_pair_t;

endpackage

//--- matrix_scan.sv
/* HUB75 scan sequencer, 64 columns per line, planes MSB to LSB per row
   pixel clocks are clk_in gated, so they run at full clk_in rate
   the next line shifts in while the previous window is still lit */
`timescale 1ns/1ps
`include "matrix_consts.svh"

module matrix_scan (
    input  logic                   reset,
    input  logic                   clk_in,
    output matrix_pkg::scan_ctrl_t ctrl,
    output matrix_pkg::scan_pos_t  pos
);

    // one extra bit so the burst length itself fits
    localparam int LOAD_BITS = `COLUMN_BITS + 1;
    localparam int LEVELS = `BRIGHTNESS_LEVELS;
    localparam logic [LEVELS-1:0] MASK_MSB = {1'b1, {(LEVELS - 1){1'b0}}};

    logic [1:0] state;
    logic state_advance;
    logic line_start;
    logic clk_pixel_load_en;
    logic clk_pixel_en;
    logic [1:0] row_latch_state;
    logic row_latch;
    logic output_enable;
    logic exceeded_overlap_time;
    logic [`COLUMN_BITS-1:0] column_address;
    logic [`ROW_BITS-1:0] row_address;
    logic [`ROW_BITS-1:0] row_address_active;
    logic [LEVELS-1:0] brightness_mask;
    logic [LEVELS-1:0] brightness_mask_active;

    // ready when the lit window is dark or inside its overlap budget
    // held off while a line is still shifting or latching
    // so every line gives a fresh rising edge
    assign state_advance = (!output_enable || exceeded_overlap_time)
                           && !clk_pixel_load_en && !row_latch;

    // newest sample in bit 0
    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= 2'b00;
        end else begin
            state <= {state[0], state_advance};
        end
    end

    // advance now, not one cycle ago
    assign line_start = (state == 2'b01);

    // load clock burst, 64 cycles
    timeout #(
        .COUNTER_WIDTH(LOAD_BITS)
    ) timeout_clk_pixel_load_en (
        .reset  (reset),
        .clk_in (clk_in),
        .start  (line_start),
        .value  (LOAD_BITS'(`PIXEL_WIDTH)),
        .counter(),
        .running(clk_pixel_load_en)
    );

    // column address, 63 first then down to 0 and hold
    timeout #(
        .COUNTER_WIDTH(`COLUMN_BITS)
    ) timeout_column_address (
        .reset  (reset),
        .clk_in (clk_in),
        .start  (line_start),
        .value  ((`COLUMN_BITS)'(`PIXEL_WIDTH - 1)),
        .counter(column_address),
        .running()
    );

    // falling burst edge, one cycle wide
    assign row_latch = (row_latch_state == 2'b10);

    always_ff @(negedge clk_in) begin
        if (reset) begin
            clk_pixel_en <= 1'b1;
            row_latch_state <= 2'b00;
            brightness_mask <= MASK_MSB;
            brightness_mask_active <= '0;
            row_address <= '0;
            row_address_active <= '0;
        end else begin
            // pixel clock trails the load clock by half a cycle
            clk_pixel_en <= clk_pixel_load_en;
            row_latch_state <= {row_latch_state[0], clk_pixel_load_en};
            if (row_latch) begin
                // freshly latched data becomes the lit line
                brightness_mask_active <= brightness_mask;
                row_address_active <= row_address;
                // LSB done, back to MSB on the next row, wraps at 16
                if ((brightness_mask == '0) || (brightness_mask == LEVELS'(1))) begin
                    brightness_mask <= MASK_MSB;
                    row_address <= row_address + 1'b1;
                end else begin
                    brightness_mask <= brightness_mask >> 1;
                end
            end
        end
    end

    // plane-weighted output enable
    brightness_timeout i_brightness_timeout (
        .clk_in                (clk_in),
        .reset                 (reset),
        .row_latch             (row_latch),
        .brightness_mask_active(brightness_mask_active),
        .output_enable         (output_enable),
        .exceeded_overlap_time (exceeded_overlap_time)
    );

    assign ctrl = '{
        clk_pixel_load: clk_in && clk_pixel_load_en,
        clk_pixel:      clk_in && clk_pixel_en,
        row_latch:      row_latch,
        output_enable:  output_enable
    };

    assign pos = '{
        column_address:     column_address,
        row_address:        row_address,
        row_address_active: row_address_active,
        brightness_mask:    brightness_mask
    };

    a_mask_onehot: assert property (
        @(posedge clk_in) disable iff (reset)
        $onehot(brightness_mask)
    ) else $error("brightness_mask not one-hot");

    // latch only after the whole burst has gone out
    a_latch_after_burst: assert property (
        @(posedge clk_in) disable iff (reset)
        !(row_latch && clk_pixel_load_en)
    ) else $error("row_latch during load burst");

    a_latch_single: assert property (
        @(posedge clk_in) disable iff (reset)
        row_latch |=> !row_latch
    ) else $error("row_latch longer than one cycle");

endmodule

//--- tb_hub75_top.sv
/* testbench for the HUB75 driver, runs two full frames (128 lines)
   outputs are sampled 10 ns into the clk_in high phase, inputs move 2 ns after posedge
   checks start on the first posedge at which the DUT sees reset low */
`timescale 1ns/1ps
`include "matrix_consts.svh"

module tb_hub75_top;

    import matrix_pkg::*;

    localparam int HALF_PERIOD = 20;
    localparam int RESET_CYCLES = 16;
    localparam int LATCH_TIMEOUT = 400;
    localparam int RUN_LINES = 2 * `PIXEL_HALFHEIGHT * `BRIGHTNESS_LEVELS;
    localparam int MASK_TOP = 1 << (`BRIGHTNESS_LEVELS - 1);

    logic clk_in;
    logic reset;
    scan_ctrl_t ctrl;
    scan_pos_t pos;
    rgb_pair_t rgb;

    // reference model of the scan
    int exp_mask = MASK_TOP;
    int exp_row = 0;
    int last_mask = 0;
    int last_row = 0;
    int load_count = 0;
    int pixel_count = 0;
    int oe_count = 0;
    int window_left = 0;
    int latch_count = 0;
    bit first_sample = 1'b1;
    bit prev_load = 1'b0;
    bit reset_at_edge = 1'b1;

    hub75_top i_hub75_top (
        .clk_in(clk_in),
        .reset (reset),
        .ctrl  (ctrl),
        .pos   (pos),
        .rgb   (rgb)
    );

    initial begin
        clk_in = 1'b0;
        forever #HALF_PERIOD clk_in = ~clk_in;
    end

    task automatic abort_run(input string reason);
        $display("%0t: %s", $time, reason);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string name, input int expected, input int actual);
        $display("FAILED at %0t: %s expected %0d actual %0d", $time, name, expected, actual);
        abort_run("value check failed");
    endtask

    // colour rule of the pattern, one bit of each channel per plane
    function automatic logic [5:0] expected_rgb(input int x, input int row, input int mask);
        int plane;
        int red;
        int green_up;
        int green_low;
        int blue_up;
        int blue_low;
        plane = 0;
        for (int i = 0; i < `BRIGHTNESS_LEVELS; i++) begin
            if (mask == (1 << i)) begin
                plane = i;
            end
        end
        red = x % 16;
        green_up = row % 16;
        green_low = (row + `PIXEL_HALFHEIGHT) % 16;
        blue_up = (x + row) % 16;
        blue_low = (x + row + `PIXEL_HALFHEIGHT) % 16;
        expected_rgb = {red[plane], green_up[plane], blue_up[plane],
                        red[plane], green_low[plane], blue_low[plane]};
    endfunction

    // one look at the outputs per clk_in cycle, mid high phase
    task automatic sample_outputs();
        int remaining;
        if (first_sample) begin
            // state right after reset
            assert (ctrl.row_latch == 1'b0)
                else report_mismatch("row_latch", 0, int'(ctrl.row_latch));
            assert (ctrl.output_enable == 1'b0)
                else report_mismatch("output_enable", 0, int'(ctrl.output_enable));
            first_sample = 1'b0;
        end
        assert (int'(pos.brightness_mask) == exp_mask)
            else report_mismatch("brightness_mask", exp_mask, int'(pos.brightness_mask));
        assert (int'(pos.row_address) == exp_row)
            else report_mismatch("row_address", exp_row, int'(pos.row_address));
        // data valid while the panel shifts it in
        if (ctrl.clk_pixel) begin
            assert (rgb == expected_rgb(int'(pos.column_address), exp_row, exp_mask))
                else report_mismatch("rgb",
                    int'(expected_rgb(int'(pos.column_address), exp_row, exp_mask)),
                    int'(rgb));
            pixel_count++;
        end
        if (ctrl.clk_pixel_load) begin
            // next line may only start inside the overlap budget
            remaining = window_left - oe_count;
            if (!prev_load && ctrl.output_enable) begin
                assert (remaining <= `BRIGHTNESS_STATE_TIMEOUT_OVERLAP)
                    else abort_run("line started with too much window left");
            end
            assert (int'(pos.column_address) == `PIXEL_WIDTH - 1 - load_count)
                else report_mismatch("column_address", `PIXEL_WIDTH - 1 - load_count,
                    int'(pos.column_address));
            load_count++;
        end
        prev_load = ctrl.clk_pixel_load;
        if (ctrl.row_latch) begin
            assert (load_count == `PIXEL_WIDTH)
                else report_mismatch("clk_pixel_load pulses", `PIXEL_WIDTH, load_count);
            assert (pixel_count == `PIXEL_WIDTH)
                else report_mismatch("clk_pixel pulses", `PIXEL_WIDTH, pixel_count);
            assert (int'(pos.row_address_active) == last_row)
                else report_mismatch("row_address_active", last_row,
                    int'(pos.row_address_active));
            assert (window_left == 0)
                else abort_run("previous output_enable window still open at row_latch");
            // window lights the plane latched one line earlier
            window_left = `BRIGHTNESS_BASE_TIMEOUT * last_mask;
            last_mask = exp_mask;
            last_row = exp_row;
            if (exp_mask == 1) begin
                exp_mask = MASK_TOP;
                exp_row = (exp_row + 1) % `PIXEL_HALFHEIGHT;
            end else begin
                exp_mask = exp_mask >> 1;
            end
            load_count = 0;
            pixel_count = 0;
            latch_count++;
        end
        if (ctrl.output_enable) begin
            oe_count++;
        end else if (oe_count > 0) begin
            assert (oe_count == window_left)
                else report_mismatch("output_enable length", window_left, oe_count);
            oe_count = 0;
            window_left = 0;
        end
    endtask

    initial begin
        forever begin
            @(posedge clk_in);
            // reset level the DUT registers on this edge
            reset_at_edge = reset;
            #10;
            if (!reset_at_edge) begin
                sample_outputs();
            end
        end
    end

    // burst is fully out when the latch comes
    a_latch_at_column_zero: assert property (
        @(posedge clk_in) disable iff (reset)
        $rose(ctrl.row_latch) |-> (pos.column_address == '0)
    ) else report_mismatch("column_address", 0, int'($sampled(pos.column_address)));

    a_dark_during_latch: assert property (
        @(posedge clk_in) disable iff (reset)
        ctrl.row_latch |-> !ctrl.output_enable
    ) else abort_run("output_enable high while row_latch is high");

    task automatic wait_for_latch(input int target);
        for (int n = 0; n < LATCH_TIMEOUT && latch_count < target; n++) begin
            @(posedge clk_in);
        end
        if (latch_count < target) begin
            abort_run("row_latch did not arrive in time");
        end
    endtask

    // model clears window_left once the window length has been checked
    task automatic wait_for_dark();
        for (int n = 0; n < LATCH_TIMEOUT && window_left != 0; n++) begin
            @(posedge clk_in);
        end
    endtask

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_in);
        #2;
        reset = 1'b0;
        for (int line = 1; line <= RUN_LINES; line++) begin
            wait_for_latch(line);
        end
        // let the last window run out so its length is checked too
        wait_for_dark();
        if (window_left == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            abort_run("last output_enable window did not end in time");
        end
    end

endmodule

//--- test_pattern.sv
/* combinational colour source, depth limited to the plane count
   red follows x, green follows y, blue follows x + y */
`timescale 1ns/1ps
`include "matrix_consts.svh"

module test_pattern (
    input  matrix_pkg::scan_pos_t pos,
    output matrix_pkg::rgb_pair_t rgb
);

    localparam int LEVELS = `BRIGHTNESS_LEVELS;

    // lower half sits 16 rows below, one extra bit for y
    logic [`ROW_BITS:0] y_upper;
    logic [`ROW_BITS:0] y_lower;
    logic [`COLUMN_BITS:0] sum_upper;
    logic [`COLUMN_BITS:0] sum_lower;

    // pick the bit of value selected by the one-hot plane mask
    function automatic logic plane_bit(
        input logic [LEVELS-1:0] value,
        input logic [LEVELS-1:0] mask
    );
        plane_bit = |(value & mask);
    endfunction

    always_comb begin
        y_upper = {1'b0, pos.row_address};
        y_lower = y_upper + (`ROW_BITS + 1)'(`PIXEL_HALFHEIGHT);
        sum_upper = {1'b0, pos.column_address} + (`COLUMN_BITS + 1)'(y_upper);
        sum_lower = {1'b0, pos.column_address} + (`COLUMN_BITS + 1)'(y_lower);

        // upper half
        rgb.r0 = plane_bit(pos.column_address[LEVELS-1:0], pos.brightness_mask);
        rgb.g0 = plane_bit(y_upper[LEVELS-1:0], pos.brightness_mask);
        rgb.b0 = plane_bit(sum_upper[LEVELS-1:0], pos.brightness_mask);

        // lower half
        rgb.r1 = plane_bit(pos.column_address[LEVELS-1:0], pos.brightness_mask);
        rgb.g1 = plane_bit(y_lower[LEVELS-1:0], pos.brightness_mask);
        rgb.b1 = plane_bit(sum_lower[LEVELS-1:0], pos.brightness_mask);
    end

endmodule

//--- timeout.sv
/* loadable down-counter, counts to zero and holds there
   a start while still counting reloads value immediately */
`timescale 1ns/1ps

module timeout #(
    parameter int COUNTER_WIDTH = 8
) (
    input  logic                     reset,
    input  logic                     clk_in,
    input  logic                     start,
    input  logic [COUNTER_WIDTH-1:0] value,
    output logic [COUNTER_WIDTH-1:0] counter,
    output logic                     running
);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            counter <= '0;
        end else if (start) begin
            // load takes priority over the count
            counter <= value;
        end else if (counter != '0) begin
            counter <= counter - 1'b1;
        end
    end

    // high for exactly value cycles after a load
    assign running = (counter != '0);

    // between loads the count only falls
    // so it never rises above what was loaded
    a_no_overshoot: assert property (
        @(posedge clk_in) disable iff (reset)
        !start |=> (counter <= $past(counter))
    ) else $error("timeout count rose without a load");

endmodule
